// ==== hw/acsi_pkg.sv ====
`default_nettype none

package acsi_pkg;

    // buffer address width, one 512 byte sector
    localparam int BUF_AW = 9;

    // parameter bytes following the first command byte
    localparam int NUM_PARMS = 5;

    // status index that returns the busy flag
    localparam int STATUS_BUSY_IDX = 6;

    // first command byte as sent on the ACSI bus
    typedef struct packed {
        logic [2:0] target;
        logic [4:0] opcode;
    } acsi_cmd_t;

    // one byte written to the ACSI data register
    // first byte decodes as target/opcode, later bytes are raw parameters
    typedef union packed {
        acsi_cmd_t  cmd;
        logic [7:0] parm;
    } acsi_byte_u;

    // one request towards the sector buffer
    typedef struct packed {
        logic              we;
        logic [BUF_AW-1:0] addr;
        logic [7:0]        wdata;
    } buf_req_t;

endpackage

`default_nettype wire

// ==== hw/sector_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module sector_buffer (
    input  logic               clk,
    input  acsi_pkg::buf_req_t mem_req,
    input  logic               mem_en,
    output logic [7:0]         buf_rdata
);

    // one sector of data
    logic [7:0] mem [2**acsi_pkg::BUF_AW];

    // single port, read data registered
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_req.we) begin
                mem[mem_req.addr] <= mem_req.wdata;
            end else begin
                buf_rdata <= mem[mem_req.addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/buffer_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module buffer_arbiter (
    // IO controller side, highest priority
    input  acsi_pkg::buf_req_t io_req,
    input  logic               io_req_valid,
    // CPU side
    input  acsi_pkg::buf_req_t cpu_req,
    input  logic               cpu_req_valid,
    output logic               io_gnt,
    output logic               cpu_gnt,
    // towards the sector buffer
    output acsi_pkg::buf_req_t mem_req,
    output logic               mem_en
);

    // IO always wins, CPU only gets the idle cycles
    assign io_gnt  = io_req_valid;
    assign cpu_gnt = cpu_req_valid & ~io_req_valid;

    // RAM is enabled whenever someone is granted
    assign mem_en = io_gnt | cpu_gnt;

    // route the winning request
    always_comb begin
        if (io_gnt) begin
            mem_req = io_req;
        end else begin
            mem_req = cpu_req;
        end
    end

endmodule

`default_nettype wire

// ==== hw/io_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module io_port (
    input  logic               clk,
    input  logic               reset,
    input  logic [2:0]         io_addr,
    input  logic               io_sel,
    input  logic               io_rw,
    input  logic [7:0]         io_din,
    output logic [7:0]         io_dout,
    // command receiver side
    input  logic [7:0]         status_byte,
    output logic               dma_ack,
    output logic               dma_nak,
    output logic [7:0]         dma_status,
    output logic [2:0]         status_sel,
    // buffer request side
    output acsi_pkg::buf_req_t io_req,
    output logic               io_req_valid,
    input  logic               io_gnt,
    input  logic [7:0]         buf_rdata
);

    logic [acsi_pkg::BUF_AW-1:0] ptr;
    logic                        rd_wait;
    logic                        io_wr;
    logic                        io_rd;

    assign io_wr = io_sel & ~io_rw;
    assign io_rd = io_sel & io_rw;

    // data access goes straight to the arbiter in the strobe cycle
    assign io_req_valid = io_sel & (io_addr == 3'd4);
    assign io_req.we    = ~io_rw;
    assign io_req.addr  = ptr;
    assign io_req.wdata = io_din;

    always_ff @(posedge clk) begin
        if (reset) begin
            status_sel <= '0;
            dma_status <= '0;
            dma_ack    <= 1'b0;
            dma_nak    <= 1'b0;
            ptr        <= '0;
            rd_wait    <= 1'b0;
        end else begin
            // single cycle answers
            dma_ack <= io_wr & (io_addr == 3'd1);
            dma_nak <= io_wr & (io_addr == 3'd2);
            rd_wait <= io_gnt & ~io_req.we;
            // auto increment on each buffer access
            if (io_gnt) begin
                ptr <= ptr + 1'b1;
            end
            if (io_wr) begin
                case (io_addr)
                    3'd0:    status_sel <= io_din[2:0];
                    3'd1:    dma_status <= io_din;
                    3'd3:    ptr <= '0;
                    default: ;
                endcase
            end
        end
    end

    // buffer data lands one cycle after a register read would
    always_ff @(posedge clk) begin
        if (rd_wait) begin
            io_dout <= buf_rdata;
        end else if (io_rd) begin
            case (io_addr)
                3'd0:    io_dout <= status_byte;
                3'd1:    io_dout <= dma_status;
                3'd4:    io_dout <= io_dout;
                default: io_dout <= 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/dma_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [1:0]           cpu_addr,
    input  logic                 cpu_sel,
    input  logic                 cpu_rw,
    input  logic [7:0]           cpu_din,
    output logic [7:0]           cpu_dout,
    // status handed over with the last ack
    input  logic [7:0]           dma_status,
    // towards the command receiver
    output logic                 acsi_wr,
    output logic                 acsi_first,
    output acsi_pkg::acsi_byte_u acsi_wdata,
    output logic                 acsi_access,
    // buffer request side
    output acsi_pkg::buf_req_t   cpu_req,
    output logic                 cpu_req_valid,
    input  logic                 cpu_gnt,
    input  logic [7:0]           buf_rdata
);

    logic [acsi_pkg::BUF_AW-1:0] ptr;
    logic                        wr_pend;
    logic                        rd_pend;
    logic                        rd_wait;
    logic                        rd_valid;
    logic [7:0]                  wr_data;
    logic [7:0]                  rd_data;
    logic                        cpu_wr;
    logic                        cpu_rd;

    assign cpu_wr = cpu_sel & ~cpu_rw;
    assign cpu_rd = cpu_sel & cpu_rw;

    // address 0 carries the first command byte, address 3 the following ones
    assign acsi_access     = cpu_sel;
    assign acsi_first      = (cpu_addr == 2'd0);
    assign acsi_wr         = cpu_wr & ((cpu_addr == 2'd0) | (cpu_addr == 2'd3));
    assign acsi_wdata.parm = cpu_din;

    // the posted write goes first, the prefetch follows
    assign cpu_req_valid = wr_pend | rd_pend;
    assign cpu_req.we    = wr_pend;
    assign cpu_req.addr  = ptr;
    assign cpu_req.wdata = wr_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr      <= '0;
            wr_pend  <= 1'b0;
            rd_pend  <= 1'b0;
            rd_wait  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            // read data shows up one cycle after the grant
            rd_wait <= cpu_gnt & ~wr_pend;
            if (rd_wait) begin
                rd_valid <= 1'b1;
            end
            if (cpu_gnt) begin
                if (wr_pend) begin
                    wr_pend <= 1'b0;
                    ptr     <= ptr + 1'b1;
                end else begin
                    rd_pend <= 1'b0;
                end
            end
            // pointer clear restarts the prefetch
            if (cpu_wr && cpu_addr == 2'd1) begin
                ptr      <= '0;
                rd_pend  <= 1'b1;
                rd_wait  <= 1'b0;
                rd_valid <= 1'b0;
            end
            // dropped while a write is still pending
            if (cpu_wr && cpu_addr == 2'd2) begin
                wr_pend <= 1'b1;
            end
            // consume the prefetched byte and fetch the next one
            if (cpu_rd && cpu_addr == 2'd2 && rd_valid) begin
                ptr      <= ptr + 1'b1;
                rd_pend  <= 1'b1;
                rd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_wait) begin
            rd_data <= buf_rdata;
        end
        if (cpu_wr && cpu_addr == 2'd2 && !wr_pend) begin
            wr_data <= cpu_din;
        end
    end

    always_comb begin
        case (cpu_addr)
            2'd0:    cpu_dout = dma_status;
            2'd1:    cpu_dout = {6'd0, rd_valid, wr_pend};
            2'd2:    cpu_dout = rd_data;
            default: cpu_dout = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/acsi_cmd.sv ====
`timescale 1ns/100ps
`default_nettype none

module acsi_cmd (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [7:0]           acsi_enable,
    // byte written by the CPU
    input  logic                 acsi_wr,
    input  logic                 acsi_first,
    input  acsi_pkg::acsi_byte_u acsi_wdata,
    // any CPU access, clears the interrupt
    input  logic                 acsi_access,
    // answers from the IO controller
    input  logic                 dma_ack,
    input  logic                 dma_nak,
    input  logic [2:0]           status_sel,
    output logic [7:0]           status_byte,
    output logic                 irq
);

    // counter runs 0 to NUM_PARMS and then sticks
    localparam int CNT_W = $clog2(acsi_pkg::NUM_PARMS + 1);

    acsi_pkg::acsi_cmd_t  cmd_reg;
    logic [7:0]           parms [acsi_pkg::NUM_PARMS];
    logic [CNT_W-1:0]     byte_cnt;
    logic                 busy;
    logic                 target_en;

    // enable of the target addressed by the stored first byte
    assign target_en = acsi_enable[cmd_reg.target];

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_reg  <= '0;
            byte_cnt <= '0;
            busy     <= 1'b0;
            irq      <= 1'b0;
        end else begin
            // IO controller finished the transfer
            if (dma_ack && busy) begin
                irq  <= 1'b1;
                busy <= 1'b0;
            end
            // no such device
            if (dma_nak) begin
                busy <= 1'b0;
            end
            // CPU touched the registers
            if (acsi_access) begin
                irq <= 1'b0;
            end
            if (acsi_wr) begin
                if (acsi_first) begin
                    cmd_reg  <= acsi_wdata.cmd;
                    byte_cnt <= '0;
                    if (acsi_enable[acsi_wdata.cmd.target]) begin
                        irq <= 1'b1;
                    end
                end else begin
                    if (byte_cnt < CNT_W'(acsi_pkg::NUM_PARMS)) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                    if (target_en) begin
                        // bytes 1 to 4 are acknowledged right away
                        if (byte_cnt < CNT_W'(acsi_pkg::NUM_PARMS - 1)) begin
                            irq <= 1'b1;
                        end else if (byte_cnt == CNT_W'(acsi_pkg::NUM_PARMS - 1)) begin
                            // last byte hands the command to the IO controller
                            busy <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // parameter storage
    always_ff @(posedge clk) begin
        if (acsi_wr && !acsi_first && byte_cnt < CNT_W'(acsi_pkg::NUM_PARMS)) begin
            parms[byte_cnt] <= acsi_wdata.parm;
        end
    end

    // status readback for the IO controller
    always_comb begin
        if (status_sel == 3'd0) begin
            status_byte = cmd_reg;
        end else if (status_sel <= 3'(acsi_pkg::NUM_PARMS)) begin
            status_byte = parms[status_sel - 3'd1];
        end else if (status_sel == 3'(acsi_pkg::STATUS_BUSY_IDX)) begin
            status_byte = {7'd0, busy};
        end else begin
            status_byte = 8'h00;
        end
    end

endmodule

`default_nettype wire

// ==== hw/acsi_dma_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module acsi_dma_top (
    input  logic       clk,
    input  logic       reset,
    // CPU register port
    input  logic [1:0] cpu_addr,
    input  logic       cpu_sel,
    input  logic       cpu_rw,
    input  logic [7:0] cpu_din,
    output logic [7:0] cpu_dout,
    // IO controller register port
    input  logic [2:0] io_addr,
    input  logic       io_sel,
    input  logic       io_rw,
    input  logic [7:0] io_din,
    output logic [7:0] io_dout,
    // one enable bit per ACSI target
    input  logic [7:0] acsi_enable,
    output logic       irq
);

    // CPU side to command receiver
    logic                 acsi_wr;
    logic                 acsi_first;
    acsi_pkg::acsi_byte_u acsi_wdata;
    logic                 acsi_access;

    // IO side to command receiver
    logic       dma_ack;
    logic       dma_nak;
    logic [7:0] dma_status;
    logic [2:0] status_sel;
    logic [7:0] status_byte;

    // buffer requests and grants
    acsi_pkg::buf_req_t io_req;
    logic               io_req_valid;
    logic               io_gnt;
    acsi_pkg::buf_req_t cpu_req;
    logic               cpu_req_valid;
    logic               cpu_gnt;
    acsi_pkg::buf_req_t mem_req;
    logic               mem_en;
    logic [7:0]         buf_rdata;

    dma_regs dma_regs_i (
        .clk           (clk),
        .reset         (reset),
        .cpu_addr      (cpu_addr),
        .cpu_sel       (cpu_sel),
        .cpu_rw        (cpu_rw),
        .cpu_din       (cpu_din),
        .cpu_dout      (cpu_dout),
        .dma_status    (dma_status),
        .acsi_wr       (acsi_wr),
        .acsi_first    (acsi_first),
        .acsi_wdata    (acsi_wdata),
        .acsi_access   (acsi_access),
        .cpu_req       (cpu_req),
        .cpu_req_valid (cpu_req_valid),
        .cpu_gnt       (cpu_gnt),
        .buf_rdata     (buf_rdata)
    );

    acsi_cmd acsi_cmd_i (
        .clk         (clk),
        .reset       (reset),
        .acsi_enable (acsi_enable),
        .acsi_wr     (acsi_wr),
        .acsi_first  (acsi_first),
        .acsi_wdata  (acsi_wdata),
        .acsi_access (acsi_access),
        .dma_ack     (dma_ack),
        .dma_nak     (dma_nak),
        .status_sel  (status_sel),
        .status_byte (status_byte),
        .irq         (irq)
    );

    io_port io_port_i (
        .clk          (clk),
        .reset        (reset),
        .io_addr      (io_addr),
        .io_sel       (io_sel),
        .io_rw        (io_rw),
        .io_din       (io_din),
        .io_dout      (io_dout),
        .status_byte  (status_byte),
        .dma_ack      (dma_ack),
        .dma_nak      (dma_nak),
        .dma_status   (dma_status),
        .status_sel   (status_sel),
        .io_req       (io_req),
        .io_req_valid (io_req_valid),
        .io_gnt       (io_gnt),
        .buf_rdata    (buf_rdata)
    );

    buffer_arbiter buffer_arbiter_i (
        .io_req        (io_req),
        .io_req_valid  (io_req_valid),
        .cpu_req       (cpu_req),
        .cpu_req_valid (cpu_req_valid),
        .io_gnt        (io_gnt),
        .cpu_gnt       (cpu_gnt),
        .mem_req       (mem_req),
        .mem_en        (mem_en)
    );

    sector_buffer sector_buffer_i (
        .clk       (clk),
        .mem_req   (mem_req),
        .mem_en    (mem_en),
        .buf_rdata (buf_rdata)
    );

endmodule

`default_nettype wire

// ==== dv/tb_acsi_dma.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_acsi_dma;

    logic       clk;
    logic       reset;
    logic [1:0] cpu_addr;
    logic       cpu_sel;
    logic       cpu_rw;
    logic [7:0] cpu_din;
    logic [7:0] cpu_dout;
    logic [2:0] io_addr;
    logic       io_sel;
    logic       io_rw;
    logic [7:0] io_din;
    logic [7:0] io_dout;
    logic [7:0] acsi_enable;
    logic       irq;

    logic [31:0] lfsr_state;

    // reference model of command store, flags and sector buffer
    logic [7:0] model_cmd;
    logic [7:0] model_parms [acsi_pkg::NUM_PARMS];
    int         model_cnt;
    logic       model_busy;
    logic       model_irq;
    logic [7:0] model_status;
    logic [7:0] model_buf [2**acsi_pkg::BUF_AW];

    acsi_dma_top acsi_dma_top_i (
        .clk         (clk),
        .reset       (reset),
        .cpu_addr    (cpu_addr),
        .cpu_sel     (cpu_sel),
        .cpu_rw      (cpu_rw),
        .cpu_din     (cpu_din),
        .cpu_dout    (cpu_dout),
        .io_addr     (io_addr),
        .io_sel      (io_sel),
        .io_rw       (io_rw),
        .io_din      (io_din),
        .io_dout     (io_dout),
        .acsi_enable (acsi_enable),
        .irq         (irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 32 bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one LFSR step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_irq();
        check_value("irq", {7'd0, irq}, {7'd0, model_irq});
    endtask

    // one CPU cycle, dout is combinational so it is taken before the rising edge
    task automatic cpu_access(input logic [1:0] addr, input logic rw, input logic [7:0] din,
                              output logic [7:0] dout);
        @(negedge clk);
        cpu_addr = addr;
        cpu_rw   = rw;
        cpu_din  = din;
        cpu_sel  = 1'b1;
        #1;
        dout = cpu_dout;
        @(negedge clk);
        cpu_sel = 1'b0;
        // any CPU access drops the interrupt
        model_irq = 1'b0;
    endtask

    task automatic cpu_write(input logic [1:0] addr, input logic [7:0] din);
        logic [7:0] unused;
        cpu_access(addr, 1'b0, din, unused);
    endtask

    task automatic cpu_read(input logic [1:0] addr, output logic [7:0] dout);
        cpu_access(addr, 1'b1, 8'h00, dout);
    endtask

    // strobe, then two idle cycles before the next IO access
    task automatic io_access(input logic [2:0] addr, input logic rw, input logic [7:0] din,
                             output logic [7:0] dout);
        @(negedge clk);
        io_addr = addr;
        io_rw   = rw;
        io_din  = din;
        io_sel  = 1'b1;
        @(negedge clk);
        io_sel = 1'b0;
        // register reads are ready one cycle after the strobe
        dout = io_dout;
        @(negedge clk);
        // buffer reads need the RAM cycle on top
        if (addr == 3'd4) begin
            dout = io_dout;
        end
    endtask

    task automatic io_write(input logic [2:0] addr, input logic [7:0] din);
        logic [7:0] unused;
        io_access(addr, 1'b0, din, unused);
    endtask

    task automatic io_read(input logic [2:0] addr, output logic [7:0] dout);
        io_access(addr, 1'b1, 8'h00, dout);
    endtask

    // status byte as the IO controller should see it
    function automatic logic [7:0] expected_status(input int idx);
        if (idx == 0) begin
            return model_cmd;
        end else if (idx <= acsi_pkg::NUM_PARMS) begin
            return model_parms[idx-1];
        end else if (idx == acsi_pkg::STATUS_BUSY_IDX) begin
            return {7'd0, model_busy};
        end
        return 8'h00;
    endfunction

    task automatic check_status(input logic [2:0] idx);
        logic [7:0] v;
        io_write(3'd0, {5'd0, idx});
        io_read(3'd0, v);
        check_value($sformatf("status[%0d]", idx), v, expected_status(idx));
    endtask

    task automatic send_first(input logic [7:0] b);
        cpu_write(2'd0, b);
        model_cmd = b;
        model_cnt = 0;
        // target sits in the top three bits
        if (acsi_enable[b[7:5]]) begin
            model_irq = 1'b1;
        end
        check_irq();
    endtask

    task automatic send_parm(input logic [7:0] b);
        cpu_write(2'd3, b);
        if (model_cnt < acsi_pkg::NUM_PARMS) begin
            model_parms[model_cnt] = b;
            if (acsi_enable[model_cmd[7:5]]) begin
                // bytes 1 to 4 interrupt, byte 5 hands over to the IO side
                if (model_cnt + 1 < acsi_pkg::NUM_PARMS) begin
                    model_irq = 1'b1;
                end else begin
                    model_busy = 1'b1;
                end
            end
            model_cnt++;
        end
        check_irq();
    endtask

    // full command to a target that is forced on
    task automatic send_command();
        logic [31:0] r;
        rand_bits(8, r);
        acsi_enable = r[7:0];
        rand_bits(8, r);
        acsi_enable[r[7:5]] = 1'b1;
        send_first(r[7:0]);
        for (int k = 0; k < acsi_pkg::NUM_PARMS; k++) begin
            rand_bits(8, r);
            send_parm(r[7:0]);
        end
    endtask

    task automatic io_ack(input logic [7:0] st);
        io_write(3'd1, st);
        model_status = st;
        if (model_busy) begin
            model_irq  = 1'b1;
            model_busy = 1'b0;
        end
        check_irq();
    endtask

    task automatic io_nak();
        io_write(3'd2, 8'h00);
        model_busy = 1'b0;
        check_irq();
    endtask

    // poll the CPU status register until a bit reaches a value
    task automatic wait_cpu_bit(input int bit_idx, input logic want);
        int         tries;
        logic       done;
        logic [7:0] st;
        tries = 0;
        done  = 1'b0;
        while (!done && tries < 64) begin
            cpu_read(2'd1, st);
            done = (st[bit_idx] == want);
            tries++;
        end
        if (!done) begin
            stop_with_error($sformatf("timeout: CPU status bit %0d never became %0b",
                                      bit_idx, want));
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [7:0]  v;
        logic [2:0]  idx_list [12];
        int          n;
        lfsr_state   = 32'h23fa;
        reset        = 1'b1;
        cpu_addr     = '0;
        cpu_sel      = 1'b0;
        cpu_rw       = 1'b0;
        cpu_din      = '0;
        io_addr      = '0;
        io_sel       = 1'b0;
        io_rw        = 1'b0;
        io_din       = '0;
        acsi_enable  = '0;
        model_cmd    = '0;
        model_cnt    = 0;
        model_busy   = 1'b0;
        model_irq    = 1'b0;
        model_status = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // idle state after reset
        check_irq();
        cpu_read(2'd1, v);
        check_value("cpu_status", v, 8'h00);
        cpu_read(2'd0, v);
        check_value("dma_status", v, 8'h00);
        check_status(3'd0);
        check_status(3'd6);

        // first bytes to random targets, irq only when the target is on
        for (int i = 0; i < 24; i++) begin
            rand_bits(8, r);
            acsi_enable = r[7:0];
            rand_bits(8, r);
            send_first(r[7:0]);
            cpu_read(2'd3, v);
            check_value("cpu_reg3", v, 8'h00);
            check_irq();
        end

        // full commands, each finished by an ack
        for (int i = 0; i < 4; i++) begin
            send_command();
            for (int s = 0; s < 8; s++) begin
                check_status(3'(s));
            end
            rand_bits(8, r);
            io_ack(r[7:0]);
            check_status(3'd6);
            cpu_read(2'd0, v);
            check_value("dma_status", v, model_status);
            check_irq();
        end

        // nak drops busy without an interrupt
        send_command();
        check_status(3'd6);
        io_nak();
        check_status(3'd6);

        // ack while idle raises nothing
        rand_bits(8, r);
        io_ack(r[7:0]);
        cpu_read(2'd0, v);
        check_value("dma_status", v, model_status);

        // IO fills a block, CPU reads it back through the prefetch
        rand_bits(5, r);
        n = 16 + int'(r[4:0]);
        io_write(3'd3, 8'h00);
        for (int i = 0; i < n; i++) begin
            rand_bits(8, r);
            model_buf[i] = r[7:0];
            io_write(3'd4, r[7:0]);
        end
        cpu_write(2'd1, 8'h00);
        for (int i = 0; i < n; i++) begin
            wait_cpu_bit(1, 1'b1);
            cpu_read(2'd2, v);
            check_value($sformatf("cpu_buf[%0d]", i), v, model_buf[i]);
        end

        // CPU writes a block while the IO side reads status
        rand_bits(5, r);
        n = 16 + int'(r[4:0]);
        for (int i = 0; i < n; i++) begin
            rand_bits(8, r);
            model_buf[i] = r[7:0];
        end
        for (int j = 0; j < 12; j++) begin
            rand_bits(3, r);
            idx_list[j] = r[2:0];
        end
        fork
            begin
                cpu_write(2'd1, 8'h00);
                for (int i = 0; i < n; i++) begin
                    wait_cpu_bit(0, 1'b0);
                    cpu_write(2'd2, model_buf[i]);
                end
                // last posted write must reach the RAM
                wait_cpu_bit(0, 1'b0);
            end
            begin
                for (int j = 0; j < 12; j++) begin
                    check_status(idx_list[j]);
                end
            end
        join
        io_write(3'd3, 8'h00);
        for (int i = 0; i < n; i++) begin
            io_read(3'd4, v);
            check_value($sformatf("io_buf[%0d]", i), v, model_buf[i]);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/acsi_pkg.sv
hw/sector_buffer.sv
hw/buffer_arbiter.sv
hw/io_port.sv
hw/dma_regs.sv
hw/acsi_cmd.sv
hw/acsi_dma_top.sv
dv/tb_acsi_dma.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_acsi_dma -o tb_acsi_dma

./obj_dir/tb_acsi_dma 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi
echo "simulation passed"
